//--- hdl/alu_width_pkg.sv
// alu width package: word, lane, shift amount and bit count types of the ALU datapath
package alu_width_pkg;

  // data word of the integer pipeline
  localparam int WORD_W  = 32;
  // byte lanes in one word, the smallest vector element
  localparam int LANES_8 = 4;

  typedef logic [WORD_W-1:0]  word_t;

  // one flag per byte lane (equal, greater, signed)
  typedef logic [LANES_8-1:0] lane_mask_t;

  // 32-bit shift amount, also the widest lane amount
  typedef logic [4:0]         shamt_t;

  // bit count result, 6 bits so that 32 fits
  typedef logic [5:0]         bitcnt_t;
  typedef logic [4:0]         bitidx_t;

endpackage

//--- hdl/alu_op_pkg.sv
// alu operator package: operator and vector mode encodings of the execute stage
package alu_op_pkg;

  typedef enum logic [5:0] {
    // plain logic
    ALU_AND  = 6'b010101,
    ALU_OR   = 6'b101110,
    ALU_XOR  = 6'b101111,
    // partitioned adder
    ALU_ADD  = 6'b011000,
    ALU_SUB  = 6'b011001,
    // shifts, rotate only in 32-bit mode
    ALU_SRA  = 6'b100100,
    ALU_SRL  = 6'b100101,
    ALU_ROR  = 6'b100110,
    ALU_SLL  = 6'b100111,
    // lane comparisons, bit 0 set means unsigned
    ALU_LTS  = 6'b000000,
    ALU_LTU  = 6'b000001,
    ALU_LES  = 6'b000100,
    ALU_LEU  = 6'b000101,
    ALU_GTS  = 6'b001000,
    ALU_GTU  = 6'b001001,
    ALU_GES  = 6'b001010,
    ALU_GEU  = 6'b001011,
    ALU_EQ   = 6'b001100,
    ALU_NE   = 6'b001101,
    // scalar set-less-than, 1-bit result
    ALU_SLTS = 6'b000010,
    ALU_SLTU = 6'b000011,
    // selection
    ALU_MIN  = 6'b010000,
    ALU_MAX  = 6'b010001,
    ALU_MINU = 6'b010010,
    ALU_MAXU = 6'b010011,
    ALU_ABS  = 6'b010100,
    // bit counting
    ALU_CNT  = 6'b110100,
    ALU_CLB  = 6'b110101,
    ALU_FF1  = 6'b110110,
    ALU_FL1  = 6'b110111
  } alu_op_e;

  // lane split of a word, 2'b01 unused
  typedef enum logic [1:0] {
    VEC_MODE32 = 2'b00,
    VEC_MODE16 = 2'b10,
    VEC_MODE8  = 2'b11
  } vec_mode_e;

endpackage

//--- hdl/alu_operand_if.sv
// alu operand interface: operator, vector mode and both operands for the datapath sections
`timescale 1ns/10ps

interface alu_operand_if;

  alu_op_pkg::alu_op_e    operator;
  alu_op_pkg::vec_mode_e  vector_mode;
  alu_width_pkg::word_t   operand_a;
  alu_width_pkg::word_t   operand_b;

  // top level side
  modport src (
    output operator,
    output vector_mode,
    output operand_a,
    output operand_b
  );

  // datapath section side
  modport dp (
    input operator,
    input vector_mode,
    input operand_a,
    input operand_b
  );

endinterface

//--- hdl/alu_adder.sv
// alu adder: lane-partitioned add, subtract and negate on one, two or four lanes
`timescale 1ns/10ps

module alu_adder (
  alu_operand_if.dp            ops_i,
  output alu_width_pkg::word_t adder_result_o
);

  logic                      negate_a;
  logic                      negate_b;
  logic                      carry_in;
  alu_width_pkg::lane_mask_t lane_start;
  alu_width_pkg::word_t      op_a;
  alu_width_pkg::word_t      op_b;
  // one guard bit below each byte, 32 + 4 bits
  logic [35:0]               in_a;
  logic [35:0]               in_b;
  logic [35:0]               sum;

  assign negate_b = (ops_i.operator == alu_op_pkg::ALU_SUB);
  assign negate_a = (ops_i.operator == alu_op_pkg::ALU_ABS);
  assign carry_in = negate_a | negate_b;

  // abs forms ~a + 1, b does not take part
  assign op_a = negate_a ? ~ops_i.operand_a : ops_i.operand_a;
  assign op_b = negate_a ? '0 : (negate_b ? ~ops_i.operand_b : ops_i.operand_b);

  // bytes that open a new lane
  always_comb begin
    case (ops_i.vector_mode)
      alu_op_pkg::VEC_MODE16: lane_start = 4'b0101;
      alu_op_pkg::VEC_MODE8:  lane_start = 4'b1111;
      default:                lane_start = 4'b0001;
    endcase
  end

  // guard bits: 1+0 passes the carry through a lane,
  // c+c at a lane start swallows the lower carry and injects c
  always_comb begin
    for (int i = 0; i < alu_width_pkg::LANES_8; i++) begin
      in_a[9*i +: 9] = {op_a[8*i +: 8], lane_start[i] ? carry_in : 1'b1};
      in_b[9*i +: 9] = {op_b[8*i +: 8], lane_start[i] ? carry_in : 1'b0};
    end
  end

  assign sum = in_a + in_b;

  // drop the guard bits again
  always_comb begin
    for (int i = 0; i < alu_width_pkg::LANES_8; i++) begin
      adder_result_o[8*i +: 8] = sum[9*i+1 +: 8];
    end
  end

endmodule

//--- hdl/alu_shifter.sv
// alu shifter: lane-partitioned right shifter, left shifts and rotate via bit reversal
`timescale 1ns/10ps

module alu_shifter (
  alu_operand_if.dp            ops_i,
  output alu_width_pkg::word_t shift_result_o
);

  logic                               shift_left;
  logic                               shift_arith;
  alu_width_pkg::word_t               a_rev;
  alu_width_pkg::word_t               amt_left;
  alu_width_pkg::word_t               amt;
  alu_width_pkg::word_t               op_a;
  alu_width_pkg::word_t               right_res;
  alu_width_pkg::word_t               right_rev;
  alu_width_pkg::shamt_t              amt32;
  logic [2*alu_width_pkg::WORD_W-1:0] rot_full;

  assign shift_left  = (ops_i.operator == alu_op_pkg::ALU_SLL);
  assign shift_arith = (ops_i.operator == alu_op_pkg::ALU_SRA);

  assign a_rev = {<<{ops_i.operand_a}};

  // reversing A also reverses the lane order, so the lane amounts swap too
  always_comb begin
    amt_left = ops_i.operand_b;
    case (ops_i.vector_mode)
      alu_op_pkg::VEC_MODE16: begin
        for (int i = 0; i < 2; i++) begin
          amt_left[16*i +: 16] = ops_i.operand_b[16*(1-i) +: 16];
        end
      end
      alu_op_pkg::VEC_MODE8: begin
        for (int i = 0; i < 4; i++) begin
          amt_left[8*i +: 8] = ops_i.operand_b[8*(3-i) +: 8];
        end
      end
      default: ;
    endcase
  end

  assign op_a  = shift_left ? a_rev : ops_i.operand_a;
  assign amt   = shift_left ? amt_left : ops_i.operand_b;
  assign amt32 = amt[4:0];

  // word doubled, so the low half of a right shift is the rotate
  assign rot_full = {op_a, op_a} >> amt32;

  ////////////////////////////////////////////////////////////////////////////
  // right shift per lane
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    right_res = '0;
    case (ops_i.vector_mode)
      alu_op_pkg::VEC_MODE16: begin
        for (int i = 0; i < 2; i++) begin
          if (shift_arith) begin
            right_res[16*i +: 16] = $unsigned($signed(op_a[16*i +: 16]) >>> amt[16*i +: 4]);
          end else begin
            right_res[16*i +: 16] = op_a[16*i +: 16] >> amt[16*i +: 4];
          end
        end
      end
      alu_op_pkg::VEC_MODE8: begin
        for (int i = 0; i < 4; i++) begin
          if (shift_arith) begin
            right_res[8*i +: 8] = $unsigned($signed(op_a[8*i +: 8]) >>> amt[8*i +: 3]);
          end else begin
            right_res[8*i +: 8] = op_a[8*i +: 8] >> amt[8*i +: 3];
          end
        end
      end
      default: begin
        if (shift_arith) begin
          right_res = $unsigned($signed(op_a) >>> amt32);
        end else if (ops_i.operator == alu_op_pkg::ALU_ROR) begin
          right_res = rot_full[alu_width_pkg::WORD_W-1:0];
        end else begin
          right_res = op_a >> amt32;
        end
      end
    endcase
  end

  // undo the input reversal for left shifts
  assign right_rev      = {<<{right_res}};
  assign shift_result_o = shift_left ? right_rev : right_res;

endmodule

//--- hdl/alu_compare.sv
// alu compare: per-lane equal and greater flags, comparison mask and min/max/abs select
`timescale 1ns/10ps

module alu_compare (
  alu_operand_if.dp                 ops_i,
  input  alu_width_pkg::word_t      adder_result_i,
  output alu_width_pkg::lane_mask_t cmp_mask_o,
  output alu_width_pkg::word_t      minmax_result_o
);

  logic                      is_signed;
  logic                      is_abs;
  logic                      do_min;
  alu_width_pkg::lane_mask_t cmp_signed;
  alu_width_pkg::lane_mask_t eq_vec;
  alu_width_pkg::lane_mask_t gt_vec;
  alu_width_pkg::lane_mask_t is_equal;
  alu_width_pkg::lane_mask_t is_greater;
  alu_width_pkg::lane_mask_t sel_a;
  alu_width_pkg::word_t      cmp_b;
  alu_width_pkg::word_t      minmax_b;

  assign is_abs = (ops_i.operator == alu_op_pkg::ALU_ABS);

  always_comb begin
    case (ops_i.operator)
      alu_op_pkg::ALU_GTS, alu_op_pkg::ALU_GES,
      alu_op_pkg::ALU_LTS, alu_op_pkg::ALU_LES,
      alu_op_pkg::ALU_SLTS, alu_op_pkg::ALU_MIN,
      alu_op_pkg::ALU_MAX, alu_op_pkg::ALU_ABS: is_signed = 1'b1;
      default:                                   is_signed = 1'b0;
    endcase
  end

  // only the top byte of a lane carries the sign
  always_comb begin
    case (ops_i.vector_mode)
      alu_op_pkg::VEC_MODE8:  cmp_signed = {4{is_signed}};
      alu_op_pkg::VEC_MODE16: cmp_signed = {is_signed, 1'b0, is_signed, 1'b0};
      default:                cmp_signed = {is_signed, 3'b000};
    endcase
  end

  // abs compares a against zero
  assign cmp_b = is_abs ? '0 : ops_i.operand_b;

  // byte compare, 9 bits with the sign bit extended where signed
  always_comb begin
    for (int i = 0; i < alu_width_pkg::LANES_8; i++) begin
      eq_vec[i] = (ops_i.operand_a[8*i +: 8] == cmp_b[8*i +: 8]);
      gt_vec[i] = $signed({ops_i.operand_a[8*i+7] & cmp_signed[i], ops_i.operand_a[8*i +: 8]}) >
                  $signed({cmp_b[8*i+7] & cmp_signed[i], cmp_b[8*i +: 8]});
    end
  end

  // merge bytes into lanes, flags copied to every byte of the lane
  always_comb begin
    is_equal   = {4{&eq_vec}};
    is_greater = {4{gt_vec[3] | (eq_vec[3] & (gt_vec[2] |
                   (eq_vec[2] & (gt_vec[1] | (eq_vec[1] & gt_vec[0])))))}};
    case (ops_i.vector_mode)
      alu_op_pkg::VEC_MODE16: begin
        for (int h = 0; h < 2; h++) begin
          is_equal[2*h +: 2]   = {2{eq_vec[2*h+1] & eq_vec[2*h]}};
          is_greater[2*h +: 2] = {2{gt_vec[2*h+1] | (eq_vec[2*h+1] & gt_vec[2*h])}};
        end
      end
      alu_op_pkg::VEC_MODE8: begin
        is_equal   = eq_vec;
        is_greater = gt_vec;
      end
      default: ;
    endcase
  end

  always_comb begin
    case (ops_i.operator)
      alu_op_pkg::ALU_EQ:   cmp_mask_o = is_equal;
      alu_op_pkg::ALU_NE:   cmp_mask_o = ~is_equal;
      alu_op_pkg::ALU_GTS,
      alu_op_pkg::ALU_GTU:  cmp_mask_o = is_greater;
      alu_op_pkg::ALU_GES,
      alu_op_pkg::ALU_GEU:  cmp_mask_o = is_greater | is_equal;
      alu_op_pkg::ALU_LTS, alu_op_pkg::ALU_LTU,
      alu_op_pkg::ALU_SLTS,
      alu_op_pkg::ALU_SLTU: cmp_mask_o = ~(is_greater | is_equal);
      alu_op_pkg::ALU_LES,
      alu_op_pkg::ALU_LEU:  cmp_mask_o = ~is_greater;
      default:              cmp_mask_o = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // min / max / abs
  ////////////////////////////////////////////////////////////////////////////

  assign do_min   = (ops_i.operator == alu_op_pkg::ALU_MIN) ||
                    (ops_i.operator == alu_op_pkg::ALU_MINU);
  // abs picks between a and -a from the adder
  assign minmax_b = is_abs ? adder_result_i : ops_i.operand_b;
  assign sel_a    = is_greater ^ {4{do_min}};

  always_comb begin
    for (int i = 0; i < alu_width_pkg::LANES_8; i++) begin
      minmax_result_o[8*i +: 8] = sel_a[i] ? ops_i.operand_a[8*i +: 8] : minmax_b[8*i +: 8];
    end
  end

endmodule

//--- hdl/alu_bitcount.sv
// alu bit counter: find-first-one and population count trees for FF1, FL1, CNT and CLB
`timescale 1ns/10ps

module alu_bitcount (
  alu_operand_if.dp              ops_i,
  output alu_width_pkg::bitcnt_t bitop_result_o
);

  alu_width_pkg::word_t    a_rev;
  alu_width_pkg::word_t    ff_in;
  alu_width_pkg::bitidx_t  ff1_idx;
  alu_width_pkg::bitidx_t  fl1_idx;
  alu_width_pkg::bitidx_t  clb_cnt;
  alu_width_pkg::bitcnt_t  pop_cnt;
  logic                    ff_no_one;

  assign a_rev = {<<{ops_i.operand_a}};

  // FL1 and CLB search from the top, so they look at the reversed word
  always_comb begin
    case (ops_i.operator)
      alu_op_pkg::ALU_FL1: ff_in = a_rev;
      alu_op_pkg::ALU_CLB: ff_in = ops_i.operand_a[31] ? ~a_rev : a_rev;
      default:             ff_in = ops_i.operand_a;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // trees, level 0 is the input bits, level 5 the root
  ////////////////////////////////////////////////////////////////////////////

  for (genvar lv = 0; lv < 6; lv++) begin : g_lvl
    localparam int N = 32 >> lv;
    logic                   sel [N];
    alu_width_pkg::bitidx_t idx [N];
    alu_width_pkg::bitcnt_t cnt [N];

    for (genvar k = 0; k < N; k++) begin : g_node
      if (lv == 0) begin : g_leaf
        assign sel[k] = ff_in[k];
        assign idx[k] = alu_width_pkg::bitidx_t'(k);
        assign cnt[k] = alu_width_pkg::bitcnt_t'(ops_i.operand_a[k]);
      end else begin : g_join
        // lower half has priority, so the lowest set bit wins
        assign sel[k] = g_lvl[lv-1].sel[2*k] | g_lvl[lv-1].sel[2*k+1];
        assign idx[k] = g_lvl[lv-1].sel[2*k] ? g_lvl[lv-1].idx[2*k] :
                                                g_lvl[lv-1].idx[2*k+1];
        assign cnt[k] = g_lvl[lv-1].cnt[2*k] + g_lvl[lv-1].cnt[2*k+1];
      end
    end
  end

  assign ff1_idx   = g_lvl[5].idx[0];
  assign ff_no_one = ~g_lvl[5].sel[0];
  assign pop_cnt   = g_lvl[5].cnt[0];

  // index in the reversed word back to a bit position
  assign fl1_idx = 5'd31 - ff1_idx;
  // bit 0 of the reversed word is the sign bit itself
  assign clb_cnt = ff1_idx - 5'd1;

  always_comb begin
    case (ops_i.operator)
      alu_op_pkg::ALU_FF1: bitop_result_o = ff_no_one ? 6'd32 : {1'b0, ff1_idx};
      alu_op_pkg::ALU_FL1: bitop_result_o = ff_no_one ? 6'd32 : {1'b0, fl1_idx};
      alu_op_pkg::ALU_CLB: begin
        // no differing bit: all zeros give 0, all ones give 31
        if (ff_no_one) begin
          bitop_result_o = ops_i.operand_a[31] ? 6'd31 : 6'd0;
        end else begin
          bitop_result_o = {1'b0, clb_cnt};
        end
      end
      default:             bitop_result_o = pop_cnt;
    endcase
  end

endmodule

//--- hdl/alu_top.sv
// alu top: datapath sections, logic ops, result select and the EX-to-WB result register
`timescale 1ns/10ps

module alu_top (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  valid_i,
  input  alu_op_pkg::alu_op_e   operator_i,
  input  alu_op_pkg::vec_mode_e vector_mode_i,
  input  alu_width_pkg::word_t  operand_a_i,
  input  alu_width_pkg::word_t  operand_b_i,
  output alu_width_pkg::word_t  result_o,
  output logic                  comparison_result_o,
  output logic                  valid_o
);

  alu_width_pkg::word_t      adder_result;
  alu_width_pkg::word_t      shift_result;
  alu_width_pkg::word_t      minmax_result;
  alu_width_pkg::lane_mask_t cmp_mask;
  alu_width_pkg::bitcnt_t    bitop_result;
  alu_width_pkg::word_t      result_d;

  alu_operand_if ops_if ();

  assign ops_if.operator    = operator_i;
  assign ops_if.vector_mode = vector_mode_i;
  assign ops_if.operand_a   = operand_a_i;
  assign ops_if.operand_b   = operand_b_i;

  alu_adder adder_i (
    .ops_i          (ops_if.dp),
    .adder_result_o (adder_result)
  );

  alu_shifter shifter_i (
    .ops_i          (ops_if.dp),
    .shift_result_o (shift_result)
  );

  alu_compare compare_i (
    .ops_i           (ops_if.dp),
    .adder_result_i  (adder_result),
    .cmp_mask_o      (cmp_mask),
    .minmax_result_o (minmax_result)
  );

  alu_bitcount bitcount_i (
    .ops_i          (ops_if.dp),
    .bitop_result_o (bitop_result)
  );

  ////////////////////////////////////////////////////////////////////////////
  // result select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    result_d = '0;
    case (operator_i)
      alu_op_pkg::ALU_AND: result_d = operand_a_i & operand_b_i;
      alu_op_pkg::ALU_OR:  result_d = operand_a_i | operand_b_i;
      alu_op_pkg::ALU_XOR: result_d = operand_a_i ^ operand_b_i;
      alu_op_pkg::ALU_ADD,
      alu_op_pkg::ALU_SUB: result_d = adder_result;
      alu_op_pkg::ALU_SLL, alu_op_pkg::ALU_SRL,
      alu_op_pkg::ALU_SRA, alu_op_pkg::ALU_ROR: result_d = shift_result;
      alu_op_pkg::ALU_MIN, alu_op_pkg::ALU_MINU,
      alu_op_pkg::ALU_MAX, alu_op_pkg::ALU_MAXU,
      alu_op_pkg::ALU_ABS: result_d = minmax_result;
      alu_op_pkg::ALU_EQ, alu_op_pkg::ALU_NE,
      alu_op_pkg::ALU_GTS, alu_op_pkg::ALU_GTU,
      alu_op_pkg::ALU_GES, alu_op_pkg::ALU_GEU,
      alu_op_pkg::ALU_LTS, alu_op_pkg::ALU_LTU,
      alu_op_pkg::ALU_LES, alu_op_pkg::ALU_LEU: begin
        // each lane flag fills its bytes
        for (int i = 0; i < alu_width_pkg::LANES_8; i++) begin
          result_d[8*i +: 8] = {8{cmp_mask[i]}};
        end
      end
      // scalar compare, top lane flag only
      alu_op_pkg::ALU_SLTS,
      alu_op_pkg::ALU_SLTU: result_d = alu_width_pkg::word_t'(cmp_mask[3]);
      alu_op_pkg::ALU_FF1, alu_op_pkg::ALU_FL1,
      alu_op_pkg::ALU_CNT,
      alu_op_pkg::ALU_CLB: result_d = alu_width_pkg::word_t'(bitop_result);
      default: ;
    endcase
  end

  // EX-to-WB register, result held while no new operation comes in
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      valid_o             <= 1'b0;
      result_o            <= '0;
      comparison_result_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        result_o            <= result_d;
        comparison_result_o <= cmp_mask[3];
      end
    end
  end

endmodule

//--- sim/alu_clk_gen.sv
// alu clock generator: 100 ns clock and an active-low reset held for the first 3 cycles
`timescale 1ns/10ps

module alu_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int HALF_PERIOD  = 50;
  localparam int RESET_CYCLES = 3;

  initial begin
    clk_o = 1'b0;
    forever begin
      #HALF_PERIOD clk_o = ~clk_o;
    end
  end

  // release on a falling edge, away from the sampling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

//--- sim/alu_tb.sv
// alu testbench checking pattern file operations, random lane add/sub and valid timing
`timescale 1ns/10ps

module alu_tb;

  localparam PATTERN_FILE = "sim/alu_patterns.txt";
  localparam int RESET_LIMIT = 10;
  localparam int VALID_LIMIT = 5;
  localparam int RANDOM_OPS  = 40;

  logic                  clk;
  logic                  rst_n;
  logic                  valid_in;
  alu_op_pkg::alu_op_e   op_in;
  alu_op_pkg::vec_mode_e mode_in;
  logic [31:0]           a_in;
  logic [31:0]           b_in;
  logic [31:0]           result;
  logic                  cmp_bit;
  logic                  valid_out;

  int seed;
  int errors;
  int checks;
  // a wait that runs out stops all later steps
  logic timed_out;

  alu_clk_gen clk_gen_i (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  alu_top dut_i (
    .clk                 (clk),
    .rst_n_i             (rst_n),
    .valid_i             (valid_in),
    .operator_i          (op_in),
    .vector_mode_i       (mode_in),
    .operand_a_i         (a_in),
    .operand_b_i         (b_in),
    .result_o            (result),
    .comparison_result_o (cmp_bit),
    .valid_o             (valid_out)
  );

  ////////////////////////////////////////////////////////////////////////////
  // reference model and reporting
  ////////////////////////////////////////////////////////////////////////////

  // per-lane add or subtract where carries never cross a lane boundary
  function automatic logic [31:0] lane_addsub(input logic [31:0] a, input logic [31:0] b,
                                              input logic sub, input int lane_w);
    logic [31:0] r;
    logic [31:0] x;
    logic [31:0] y;
    logic [31:0] mask;
    r    = '0;
    mask = (lane_w == 32) ? 32'hffffffff : ((32'd1 << lane_w) - 32'd1);
    for (int pos = 0; pos < 32; pos += lane_w) begin
      x = (a >> pos) & mask;
      y = (b >> pos) & mask;
      r = r | (((sub ? x - y : x + y) & mask) << pos);
    end
    return r;
  endfunction

  task automatic finish_run();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // drive and check
  ////////////////////////////////////////////////////////////////////////////

  // called at a falling edge and captured at the next rising edge
  task automatic issue_op(input logic [5:0] op, input logic [1:0] mode,
                          input logic [31:0] a, input logic [31:0] b);
    valid_in = 1'b1;
    op_in    = alu_op_pkg::alu_op_e'(op);
    mode_in  = alu_op_pkg::vec_mode_e'(mode);
    a_in     = a;
    b_in     = b;
  endtask

  // valid_i stays high through reset and the output register must ignore it
  task automatic check_reset();
    int cycles;
    cycles = 0;
    @(posedge clk);
    while (!rst_n && cycles < RESET_LIMIT) begin
      @(negedge clk);
      checks++;
      if (valid_out !== 1'b0) begin
        errors++;
        $display("valid_o is high while reset is held");
      end
      if (result !== 32'h0 || cmp_bit !== 1'b0) begin
        errors++;
        $display("error reset_result: expected 00000000/0, actual %08h/%b", result, cmp_bit);
      end
      @(posedge clk);
      cycles++;
    end
    if (!rst_n) begin
      errors++;
      timed_out = 1'b1;
      $display("reset did not release within timeout");
    end
  endtask

  // expected one cycle after issue and checked at a falling edge
  task automatic wait_valid(input string name);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (valid_out !== 1'b1 && cycles < VALID_LIMIT);
    if (valid_out !== 1'b1) begin
      errors++;
      timed_out = 1'b1;
      $display("%s: no valid_o within timeout", name);
    end else if (cycles != 1) begin
      errors++;
      $display("%s: valid_o came %0d cycles after issue instead of 1", name, cycles);
    end
  endtask

  task automatic check_result(input string name, input logic [31:0] exp_res,
                              input logic exp_cmp);
    checks++;
    if (result !== exp_res) begin
      errors++;
      $display("error %s: expected %08h, actual %08h", name, exp_res, result);
    end
    checks++;
    if (cmp_bit !== exp_cmp) begin
      errors++;
      $display("error %s comparison: expected %b, actual %b", name, exp_cmp, cmp_bit);
    end
  endtask

  // valid_i was just dropped so valid_o falls and result_o holds
  task automatic check_drop(input string name, input logic [31:0] held);
    @(negedge clk);
    checks++;
    if (valid_out !== 1'b0) begin
      errors++;
      $display("%s: valid_o still high one cycle after valid_i dropped", name);
    end
    if (result !== held) begin
      errors++;
      $display("error %s hold: expected %08h, actual %08h", name, held, result);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  // operations are read one per line and issued back to back
  task automatic pattern_test();
    int          fd;
    int          n;
    int          count;
    string       line;
    string       name;
    logic [31:0] op_code;
    logic [31:0] mode_code;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] exp_res;
    logic [31:0] exp_cmp;
    count = 0;
    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) begin
      errors++;
      $display("cannot open pattern file %s", PATTERN_FILE);
    end else begin
      while (!timed_out && $fgets(line, fd) != 0) begin
        n = $sscanf(line, "%s %h %h %h %h %h %h", name, op_code, mode_code, a, b,
                    exp_res, exp_cmp);
        // comment and blank lines hold no operation
        if (line.getc(0) != "#" && n == 7) begin
          issue_op(op_code[5:0], mode_code[1:0], a, b);
          wait_valid(name);
          if (!timed_out) begin
            check_result(name, exp_res, exp_cmp[0]);
            count++;
          end
        end else if (line.getc(0) != "#" && n > 0) begin
          errors++;
          $display("malformed pattern line: %s", line);
        end
      end
      $fclose(fd);
      if (count == 0) begin
        errors++;
        $display("no operations read from the pattern file");
      end
    end
  endtask

  // random operands and lane modes with expected sums from lane_addsub
  task automatic random_addsub_test(output logic [31:0] last_res);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] rnd;
    logic [31:0] mode_sel;
    logic [31:0] expected;
    logic [1:0]  mode_bits;
    logic        sub;
    int          lane_w;
    string       name;
    last_res = '0;
    for (int i = 0; i < RANDOM_OPS && !timed_out; i++) begin
      a        = $random(seed);
      b        = $random(seed);
      rnd      = $random(seed);
      sub      = rnd[0];
      mode_sel = (rnd >> 1) % 32'd3;
      case (mode_sel)
        32'd1: begin
          mode_bits = alu_op_pkg::VEC_MODE16;
          lane_w    = 16;
        end
        32'd2: begin
          mode_bits = alu_op_pkg::VEC_MODE8;
          lane_w    = 8;
        end
        default: begin
          mode_bits = alu_op_pkg::VEC_MODE32;
          lane_w    = 32;
        end
      endcase
      expected = lane_addsub(a, b, sub, lane_w);
      name     = $sformatf("rand_%s%0d_%0d", sub ? "sub" : "add", lane_w, i);
      issue_op(sub ? alu_op_pkg::ALU_SUB : alu_op_pkg::ALU_ADD, mode_bits, a, b);
      wait_valid(name);
      if (!timed_out) begin
        check_result(name, expected, 1'b0);
        last_res = expected;
      end
    end
  endtask

  initial begin
    logic [31:0] last_res;
    seed      = 27;
    errors    = 0;
    checks    = 0;
    timed_out = 1'b0;
    valid_in  = 1'b1;
    op_in     = alu_op_pkg::ALU_AND;
    mode_in   = alu_op_pkg::VEC_MODE32;
    a_in      = 32'hffffffff;
    b_in      = 32'h0000ffff;

    check_reset();
    // the AND still on the inputs issues at the first edge out of reset
    if (!timed_out) begin
      wait_valid("and_after_reset");
    end
    if (!timed_out) begin
      check_result("and_after_reset", 32'h0000ffff, 1'b0);
      valid_in = 1'b0;
      check_drop("and_after_reset", 32'h0000ffff);
      pattern_test();
    end
    if (!timed_out) begin
      random_addsub_test(last_res);
    end
    if (!timed_out) begin
      valid_in = 1'b0;
      check_drop("random_end", last_res);
    end

    finish_run();
  end

endmodule

//--- sim/alu_patterns.txt
# name  op(hex)  mode(0=32,2=16,3=8)  operand_a  operand_b  expected_result  expected_cmp
# op codes as in alu_op_pkg, all values in hex
and_32    15 0 f0f0ff00 ff0f0ff0 f0000f00 0
or_32     2e 0 12340000 0000abcd 1234abcd 0
xor_32    2f 0 ffff0000 0f0f0f0f f0f00f0f 0
add_32    18 0 7fffffff 00000001 80000000 0
add_16    18 2 ffff0001 00010002 00000003 0
add_8     18 3 ff7f8001 01010180 00808181 0
sub_16    19 2 00000005 00010007 fffffffe 0
sub_8     19 3 00102030 01010101 ff0f1f2f 0
sll_32    27 0 00000001 0000001f 80000000 0
sll_8     27 3 01010101 00010203 01020408 0
srl_16    25 2 80008000 000f0004 00010800 0
sra_32    24 0 80000000 0000001f ffffffff 0
sra_16    24 2 80008000 000f0004 fffff800 0
sra_8     24 3 80407f81 07010203 ff201ff0 0
ror_32    26 0 00000012 00000004 20000001 0
lts_8     00 3 ff017f00 0102807f ffff00ff 1
ltu_8     01 3 ff017f00 0102807f 00ffffff 0
les_8     04 3 80017f05 80027e06 ffff00ff 1
gts_16    08 2 80000001 7fff0000 0000ffff 0
geu_32    0b 0 80000000 7fffffff ffffffff 1
eq_16     0c 2 12345678 12345679 ffff0000 1
ne_8      0d 3 11223344 11003300 00ff00ff 0
slts_32   02 0 80000000 00000001 00000001 1
sltu_32   03 0 80000000 00000001 00000000 0
min_16    10 2 8000000a 7fff0005 80000005 0
minu_16   12 2 8000000a 7fff0005 7fff0005 0
max_8     11 3 80017f10 7f028020 7f027f20 0
maxu_8    13 3 80017f10 7f028020 80028020 0
abs_8     14 3 80ff0305 12345678 80010305 0
abs_32    14 0 fffffff6 12345678 0000000a 0
ff1_32    36 0 00012000 00000000 0000000d 0
ff1_zero  36 0 00000000 00000000 00000020 0
fl1_32    37 0 00012000 00000000 00000010 0
fl1_zero  37 0 00000000 00000000 00000020 0
cnt_32    34 0 f0f00001 00000000 00000009 0
clb_neg   35 0 fff00000 00000000 0000000b 0
clb_pos   35 0 00000100 00000000 00000016 0
clb_ones  35 0 ffffffff 00000000 0000001f 0
clb_zero  35 0 00000000 00000000 00000000 0

//--- build.f
hdl/alu_width_pkg.sv
hdl/alu_op_pkg.sv
hdl/alu_operand_if.sv
hdl/alu_adder.sv
hdl/alu_shifter.sv
hdl/alu_compare.sv
hdl/alu_bitcount.sv
hdl/alu_top.sv
sim/alu_clk_gen.sv
sim/alu_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the ALU testbench with Verilator, run it and check the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module alu_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/Valu_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "All tests passed"; then
  exit 0
fi

echo "simulation reported failures"
exit 1
